//--- Bender.yml
package:
  name: dbg_engine

sources:
  - files:
      - hdl/dbg_pkg.sv
      - hdl/dbg_xfer_regs.sv
      - hdl/dbg_reply_stage.sv
      - hdl/dbg_ctrl.sv
      - hdl/dbg_top.sv
  - target: simulation
    files:
      - sim/dbg_properties.sv
      - sim/tb_dbg.sv

//--- compile.f
hdl/dbg_pkg.sv
hdl/dbg_xfer_regs.sv
hdl/dbg_reply_stage.sv
hdl/dbg_ctrl.sv
hdl/dbg_top.sv
sim/dbg_properties.sv
sim/tb_dbg.sv

//--- hdl/dbg_ctrl.sv
/* Debug command controller
   Decodes command packets and sequences header, data, bus strobes and replies */

`default_nettype none

module dbg_ctrl
  import dbg_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       brk,             // CPU initiated break
  input  wire byte_t      rx_data,         // Show-ahead receive byte
  input  wire logic       rx_empty,
  input  wire logic       tx_full,
  input  wire addr_t      addr,            // Address register, low byte holds reg select
  input  wire logic       len_zero,        // Length in CNT_HI cycle is zero
  input  wire logic       cnt_last,        // Count equals one
  input  wire logic       cnt_odd,         // Count bit 0, send phase of a read
  output logic            rx_rd,
  output logic            active,
  output logic            cpu_r_nw,
  output reg_sel_t        cpu_dbgreg_sel,
  output logic            cpu_dbgreg_wr,
  output logic            addr_ld_lo,
  output logic            addr_ld_hi,
  output logic            addr_inc,
  output logic            cnt_ld_lo,
  output logic            cnt_ld_hi,
  output logic            cnt_dbl,
  output logic            cnt_dec,
  output logic            reply_push,
  output reply_src_e      reply_src,
  output logic            err_unknown_op
);

  dbg_state_e state_q, state_d;
  logic [1:0] hdr_cnt_q, hdr_cnt_d;  // Header byte index after opcode

  logic    can_pop;   // Receive byte available
  logic    can_push;  // Room in transmit FIFO
  logic    hdr_last_mem;
  logic    hdr_last_echo;
  dbg_op_e op;

  assign can_pop       = !rx_empty;
  assign can_push      = !tx_full;
  assign hdr_last_mem  = (hdr_cnt_q == 2'(HDR_BYTES_MEM - 1));
  assign hdr_last_echo = (hdr_cnt_q == 2'(HDR_BYTES_ECHO - 1));
  assign op            = dbg_op_e'(rx_data);

  assign active = (state_q != S_DISABLED);

  ////////////////////////////////////////
  // State registers
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= S_DISABLED;
      hdr_cnt_q <= '0;
    end
    else
    begin
      state_q   <= state_d;
      hdr_cnt_q <= hdr_cnt_d;
    end
  end

  ////////////////////////////////////////
  // Next state and strobes
  ////////////////////////////////////////

  always_comb
  begin
    // Hold by default, all strobes idle
    state_d        = state_q;
    hdr_cnt_d      = hdr_cnt_q;
    rx_rd          = 1'b0;
    cpu_r_nw       = 1'b1;
    cpu_dbgreg_sel = '0;
    cpu_dbgreg_wr  = 1'b0;
    addr_ld_lo     = 1'b0;
    addr_ld_hi     = 1'b0;
    addr_inc       = 1'b0;
    cnt_ld_lo      = 1'b0;
    cnt_ld_hi      = 1'b0;
    cnt_dbl        = 1'b0;
    cnt_dec        = 1'b0;
    reply_push     = 1'b0;
    reply_src      = SRC_ECHO;
    err_unknown_op = 1'b0;

    case (state_q)
      S_DISABLED:
      begin
        if (brk)
          state_d = S_DECODE;  // CPU hit a breakpoint
        else if (can_pop && (can_push || op != OP_QUERY_DBG_BRK))
        begin
          rx_rd = 1'b1;  // Other opcodes dropped while running
          if (op == OP_DBG_BRK)
            state_d = S_DECODE;
          else if (op == OP_QUERY_DBG_BRK)
          begin
            reply_push = 1'b1;
            reply_src  = SRC_BRK_NO;
          end
        end
      end

      S_DECODE:
      begin
        // Status query holds its opcode until a reply slot is free
        if (can_pop && (can_push || op != OP_QUERY_DBG_BRK))
        begin
          rx_rd     = 1'b1;
          hdr_cnt_d = '0;
          case (op)
            OP_ECHO:           state_d = S_ECHO_HDR;
            OP_CPU_MEM_RD:     state_d = S_MEM_RD_HDR;
            OP_CPU_MEM_WR:     state_d = S_MEM_WR_HDR;
            OP_DBG_BRK:        state_d = S_DECODE;  // Already in break
            OP_DBG_RUN:        state_d = S_DISABLED;
            OP_CPU_REG_RD:     state_d = S_REG_RD;
            OP_CPU_REG_WR:     state_d = S_REG_WR_SEL;
            OP_QUERY_ERR_CODE: state_d = S_QUERY_ERR;
            OP_QUERY_DBG_BRK:
            begin
              reply_push = 1'b1;
              reply_src  = SRC_BRK_YES;
            end
            default:
              err_unknown_op = 1'b1;  // Byte dropped, flag latched
          endcase
        end
      end

      // ECHO  OP CNT_LO CNT_HI DATA...
      S_ECHO_HDR:
      begin
        if (can_pop)
        begin
          rx_rd     = 1'b1;
          hdr_cnt_d = hdr_cnt_q + 2'd1;
          if (hdr_last_echo)
          begin
            cnt_ld_hi = 1'b1;
            state_d   = len_zero ? S_DECODE : S_ECHO_DATA;
          end
          else
            cnt_ld_lo = 1'b1;
        end
      end

      S_ECHO_DATA:
      begin
        if (can_pop && can_push)
        begin
          rx_rd      = 1'b1;
          reply_push = 1'b1;  // Byte goes straight back
          reply_src  = SRC_ECHO;
          cnt_dec    = 1'b1;
          if (cnt_last)
            state_d = S_DECODE;
        end
      end

      // CPU_MEM_RD / CPU_MEM_WR  OP ADDR_LO ADDR_HI CNT_LO CNT_HI [DATA...]
      S_MEM_RD_HDR, S_MEM_WR_HDR:
      begin
        if (can_pop)
        begin
          rx_rd     = 1'b1;
          hdr_cnt_d = hdr_cnt_q + 2'd1;
          if (hdr_last_mem)
          begin
            cnt_ld_hi = 1'b1;
            cnt_dbl   = (state_q == S_MEM_RD_HDR);  // Settle plus send per read byte
            if (len_zero)
              state_d = S_DECODE;
            else if (state_q == S_MEM_RD_HDR)
              state_d = S_MEM_RD_DATA;
            else
              state_d = S_MEM_WR_DATA;
          end
          else
          begin
            case (hdr_cnt_q)
              2'd0:    addr_ld_lo = 1'b1;
              2'd1:    addr_ld_hi = 1'b1;
              default: cnt_ld_lo  = 1'b1;
            endcase
          end
        end
      end

      S_MEM_RD_DATA:
      begin
        if (!cnt_odd)
          cnt_dec = 1'b1;  // Settle cycle, cpu_din follows new address
        else if (can_push)
        begin
          reply_push = 1'b1;
          reply_src  = SRC_CPU_MEM;
          addr_inc   = 1'b1;
          cnt_dec    = 1'b1;
          if (cnt_last)
            state_d = S_DECODE;
        end
      end

      S_MEM_WR_DATA:
      begin
        if (can_pop)
        begin
          rx_rd    = 1'b1;
          cpu_r_nw = 1'b0;  // Write lands at this edge
          addr_inc = 1'b1;
          cnt_dec  = 1'b1;
          if (cnt_last)
            state_d = S_DECODE;
        end
      end

      // CPU_REG_RD  OP REG_SEL
      S_REG_RD:
      begin
        if (can_pop && can_push)
        begin
          rx_rd          = 1'b1;
          cpu_dbgreg_sel = rx_data[3:0];
          reply_push     = 1'b1;
          reply_src      = SRC_CPU_REG;
          state_d        = S_DECODE;
        end
      end

      // CPU_REG_WR  OP REG_SEL DATA
      S_REG_WR_SEL:
      begin
        if (can_pop)
        begin
          rx_rd      = 1'b1;
          addr_ld_lo = 1'b1;  // Park select in address low byte
          state_d    = S_REG_WR_DATA;
        end
      end

      S_REG_WR_DATA:
      begin
        if (can_pop)
        begin
          rx_rd          = 1'b1;
          cpu_dbgreg_sel = addr[3:0];
          cpu_dbgreg_wr  = 1'b1;
          state_d        = S_DECODE;
        end
      end

      S_QUERY_ERR:
      begin
        if (can_push)
        begin
          reply_push = 1'b1;
          reply_src  = SRC_ERR_CODE;
          state_d    = S_DECODE;
        end
      end

      default:
        state_d = S_DISABLED;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/dbg_pkg.sv
/* Debug command engine shared definitions
   Bus types, opcodes, controller states, reply sources and error bit positions */

`default_nettype none

package dbg_pkg;

  ////////////////////////////////////////
  // Bus and counter types
  ////////////////////////////////////////

  typedef logic [7:0]  byte_t;     // Packet or bus byte
  typedef logic [15:0] addr_t;     // CPU address
  typedef logic [16:0] cnt_t;      // Transfer count, room for doubled read count
  typedef logic [3:0]  reg_sel_t;  // CPU debug register select

  ////////////////////////////////////////
  // Packet opcodes, values fixed by the host protocol
  ////////////////////////////////////////

  typedef enum logic [7:0] {
    OP_ECHO           = 8'h00,
    OP_CPU_MEM_RD     = 8'h01,
    OP_CPU_MEM_WR     = 8'h02,
    OP_DBG_BRK        = 8'h03,
    OP_DBG_RUN        = 8'h04,
    OP_CPU_REG_RD     = 8'h05,
    OP_CPU_REG_WR     = 8'h06,
    OP_QUERY_DBG_BRK  = 8'h07,
    OP_QUERY_ERR_CODE = 8'h08
  } dbg_op_e;

  // Controller states
  typedef enum logic [3:0] {
    S_DISABLED,     // CPU running, only break and query accepted
    S_DECODE,       // Waiting for opcode
    S_ECHO_HDR,
    S_ECHO_DATA,
    S_MEM_RD_HDR,
    S_MEM_RD_DATA,
    S_MEM_WR_HDR,
    S_MEM_WR_DATA,
    S_REG_RD,
    S_REG_WR_SEL,
    S_REG_WR_DATA,
    S_QUERY_ERR
  } dbg_state_e;

  // Reply byte source
  typedef enum logic [2:0] {
    SRC_ECHO,       // Receive byte
    SRC_CPU_MEM,    // cpu_din
    SRC_CPU_REG,    // cpu_dbgreg_in
    SRC_ERR_CODE,   // Sticky error code
    SRC_BRK_NO,     // 0x00
    SRC_BRK_YES     // 0x01
  } reply_src_e;

  // Error code bit positions, bit 0 reads 0
  localparam int ERR_UNKNOWN_OP_BIT = 1;

  // Header bytes following the opcode
  localparam int HDR_BYTES_MEM  = 4;  // ADDR_LO ADDR_HI CNT_LO CNT_HI
  localparam int HDR_BYTES_ECHO = 2;  // CNT_LO CNT_HI

endpackage

`default_nettype wire

//--- hdl/dbg_reply_stage.sv
/* Reply output stage
   Selects and registers the transmit byte, keeps the sticky error code */

`default_nettype none

module dbg_reply_stage
  import dbg_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       reply_push,
  input  wire reply_src_e reply_src,
  input  wire byte_t      rx_data,
  input  wire byte_t      cpu_din,
  input  wire byte_t      cpu_dbgreg_in,
  input  wire logic       err_unknown_op,  // One-cycle pulse from decode
  output byte_t           tx_data,
  output logic            tx_wr
);

  logic  err_unknown_q;  // Sticky until reset
  byte_t err_code;
  byte_t reply_byte;

  always_ff @(posedge clk)
  begin
    if (rst)
      err_unknown_q <= 1'b0;
    else if (err_unknown_op)
      err_unknown_q <= 1'b1;
  end

  always_comb
  begin
    err_code                     = 8'h00;  // Bit 0 unused
    err_code[ERR_UNKNOWN_OP_BIT] = err_unknown_q;
  end

  // Reply source mux
  always_comb
  begin
    case (reply_src)
      SRC_ECHO:     reply_byte = rx_data;
      SRC_CPU_MEM:  reply_byte = cpu_din;
      SRC_CPU_REG:  reply_byte = cpu_dbgreg_in;
      SRC_ERR_CODE: reply_byte = err_code;
      SRC_BRK_YES:  reply_byte = 8'h01;
      default:      reply_byte = 8'h00;  // Not in break
    endcase
  end

  ////////////////////////////////////////
  // Transmit register, one cycle after decision
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
      tx_wr <= 1'b0;
    else
      tx_wr <= reply_push;
  end

  always_ff @(posedge clk)
  begin
    if (reply_push)
      tx_data <= reply_byte;  // Held between replies
  end

endmodule

`default_nettype wire

//--- hdl/dbg_top.sv
/* Debug command engine top level
   Controller with transfer registers and reply stage between FIFOs and CPU */

`default_nettype none

module dbg_top
  import dbg_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  brk,             // CPU initiated break
  input  wire byte_t rx_data,         // Show-ahead receive FIFO
  input  wire logic  rx_empty,
  input  wire logic  tx_full,
  input  wire byte_t cpu_din,         // CPU data bus read
  input  wire byte_t cpu_dbgreg_in,   // Selected debug register read
  output logic       rx_rd,
  output byte_t      tx_data,
  output logic       tx_wr,
  output logic       active,          // Holds the CPU while high
  output logic       cpu_r_nw,
  output addr_t      cpu_a,
  output byte_t      cpu_dout,
  output reg_sel_t   cpu_dbgreg_sel,
  output byte_t      cpu_dbgreg_out,
  output logic       cpu_dbgreg_wr
);

  // Controller to datapath
  addr_t      addr;
  logic       len_zero;
  logic       cnt_last;
  logic       cnt_odd;
  logic       addr_ld_lo;
  logic       addr_ld_hi;
  logic       addr_inc;
  logic       cnt_ld_lo;
  logic       cnt_ld_hi;
  logic       cnt_dbl;
  logic       cnt_dec;
  logic       reply_push;
  reply_src_e reply_src;
  logic       err_unknown_op;

  dbg_ctrl dbg_ctrl_i (
    .clk            (clk),
    .rst            (rst),
    .brk            (brk),
    .rx_data        (rx_data),
    .rx_empty       (rx_empty),
    .tx_full        (tx_full),
    .addr           (addr),
    .len_zero       (len_zero),
    .cnt_last       (cnt_last),
    .cnt_odd        (cnt_odd),
    .rx_rd          (rx_rd),
    .active         (active),
    .cpu_r_nw       (cpu_r_nw),
    .cpu_dbgreg_sel (cpu_dbgreg_sel),
    .cpu_dbgreg_wr  (cpu_dbgreg_wr),
    .addr_ld_lo     (addr_ld_lo),
    .addr_ld_hi     (addr_ld_hi),
    .addr_inc       (addr_inc),
    .cnt_ld_lo      (cnt_ld_lo),
    .cnt_ld_hi      (cnt_ld_hi),
    .cnt_dbl        (cnt_dbl),
    .cnt_dec        (cnt_dec),
    .reply_push     (reply_push),
    .reply_src      (reply_src),
    .err_unknown_op (err_unknown_op)
  );

  dbg_xfer_regs dbg_xfer_regs_i (
    .clk        (clk),
    .rst        (rst),
    .rx_data    (rx_data),
    .addr_ld_lo (addr_ld_lo),
    .addr_ld_hi (addr_ld_hi),
    .addr_inc   (addr_inc),
    .cnt_ld_lo  (cnt_ld_lo),
    .cnt_ld_hi  (cnt_ld_hi),
    .cnt_dbl    (cnt_dbl),
    .cnt_dec    (cnt_dec),
    .addr       (addr),
    .len_zero   (len_zero),
    .cnt_last   (cnt_last),
    .cnt_odd    (cnt_odd)
  );

  dbg_reply_stage dbg_reply_stage_i (
    .clk            (clk),
    .rst            (rst),
    .reply_push     (reply_push),
    .reply_src      (reply_src),
    .rx_data        (rx_data),
    .cpu_din        (cpu_din),
    .cpu_dbgreg_in  (cpu_dbgreg_in),
    .err_unknown_op (err_unknown_op),
    .tx_data        (tx_data),
    .tx_wr          (tx_wr)
  );

  // Write data comes straight from the receive FIFO head
  assign cpu_dout       = rx_data;
  assign cpu_dbgreg_out = rx_data;
  assign cpu_a          = addr;

endmodule

`default_nettype wire

//--- hdl/dbg_xfer_regs.sv
/* Transfer address and count registers
   Bytewise load from the receive stream, address step, count step and end flags */

`default_nettype none

module dbg_xfer_regs
  import dbg_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire byte_t rx_data,
  input  wire logic  addr_ld_lo,   // Load low byte, clear high byte
  input  wire logic  addr_ld_hi,
  input  wire logic  addr_inc,
  input  wire logic  cnt_ld_lo,
  input  wire logic  cnt_ld_hi,
  input  wire logic  cnt_dbl,      // Shift count left on high byte load
  input  wire logic  cnt_dec,
  output addr_t      addr,
  output logic       len_zero,
  output logic       cnt_last,
  output logic       cnt_odd
);

  addr_t addr_q;
  cnt_t  cnt_q;

  ////////////////////////////////////////
  // Address register
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
      addr_q <= '0;
    else if (addr_ld_lo)
      addr_q <= {8'h00, rx_data};
    else if (addr_ld_hi)
      addr_q <= {rx_data, addr_q[7:0]};
    else if (addr_inc)
      addr_q <= addr_q + 16'd1;  // Wraps at top of map
  end

  ////////////////////////////////////////
  // Transfer count
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
      cnt_q <= '0;
    else if (cnt_ld_lo)
      cnt_q <= {9'd0, rx_data};
    else if (cnt_ld_hi)
    begin
      if (cnt_dbl)
        cnt_q <= {rx_data, cnt_q[7:0], 1'b0};  // Two cycles per read byte
      else
        cnt_q <= {1'b0, rx_data, cnt_q[7:0]};
    end
    else if (cnt_dec)
      cnt_q <= cnt_q - 17'd1;
  end

  // Length check sees CNT_HI on the bus and CNT_LO in the register
  assign len_zero = (rx_data == 8'h00) && (cnt_q[7:0] == 8'h00);
  assign cnt_last = (cnt_q == 17'd1);
  assign cnt_odd  = cnt_q[0];
  assign addr     = addr_q;

endmodule

`default_nettype wire

//--- sim/dbg_properties.sv
/* Debug engine protocol checks
   FIFO handshake and bus strobe rules, bound to the top level */

`default_nettype none

module dbg_properties (
  input wire logic clk,
  input wire logic rst,
  input wire logic rx_rd,
  input wire logic rx_empty,
  input wire logic tx_wr,
  input wire logic tx_full,
  input wire logic cpu_r_nw,
  input wire logic cpu_dbgreg_wr,
  input wire logic active
);

  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;  // Assertion failures so far

  // No pop from an empty FIFO
  rx_rd_not_empty: assert property (@(posedge clk) disable iff (rst) rx_rd |-> !rx_empty)
  else
  begin
    fail_count++;
    $error("rx_rd high while receive FIFO empty");
  end

  // Push decided only with room in the FIFO
  tx_wr_after_room: assert property (@(posedge clk) disable iff (rst) tx_wr |-> $past(!tx_full))
  else
  begin
    fail_count++;
    $error("tx_wr without free slot in previous cycle");
  end

  // Bus strobes only while CPU is held
  strobe_in_break: assert property (@(posedge clk) disable iff (rst)
    (!cpu_r_nw || cpu_dbgreg_wr) |-> active)
  else
  begin
    fail_count++;
    $error("CPU bus strobe outside break");
  end

  tx_wr_reset: assert property (@(posedge clk) $past(rst) |-> !tx_wr)
  else
  begin
    fail_count++;
    $error("tx_wr high right after reset");
  end

endmodule

bind dbg_top dbg_properties dbg_properties_i (
  .clk           (clk),
  .rst           (rst),
  .rx_rd         (rx_rd),
  .rx_empty      (rx_empty),
  .tx_wr         (tx_wr),
  .tx_full       (tx_full),
  .cpu_r_nw      (cpu_r_nw),
  .cpu_dbgreg_wr (cpu_dbgreg_wr),
  .active        (active)
);

`default_nettype wire

//--- sim/tb_dbg.sv
/* Debug command engine testbench
   FIFO, CPU memory and register models, random packets checked against a model */

`default_nettype none

module tb_dbg
  import dbg_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic     clk;
  logic     rst;
  logic     brk;
  byte_t    rx_data;
  logic     rx_empty;
  logic     tx_full;
  byte_t    cpu_din;
  byte_t    cpu_dbgreg_in;
  logic     rx_rd;
  byte_t    tx_data;
  logic     tx_wr;
  logic     active;
  logic     cpu_r_nw;
  addr_t    cpu_a;
  byte_t    cpu_dout;
  reg_sel_t cpu_dbgreg_sel;
  byte_t    cpu_dbgreg_out;
  logic     cpu_dbgreg_wr;

  byte_t mem [0:65535];      // CPU memory as the DUT sees it
  byte_t exp_mem [0:65535];  // Expected memory contents
  byte_t regs [0:15];        // CPU debug registers
  byte_t exp_regs [0:15];
  byte_t rx_q [$];           // Receive FIFO contents
  byte_t tx_q [$];           // Bytes taken by the sink
  byte_t pkt [$];            // Packet being built

  integer seed;
  int     full_mode;  // 0 never full, 1 random cycles, 2 random stretches
  int     full_left;  // Cycles left in current stretch
  int     errors;
  int     checks;
  int     tests;
  int     failed_tests;
  int     test_err0;

  dbg_top dbg_top_i (
    .clk            (clk),
    .rst            (rst),
    .brk            (brk),
    .rx_data        (rx_data),
    .rx_empty       (rx_empty),
    .tx_full        (tx_full),
    .cpu_din        (cpu_din),
    .cpu_dbgreg_in  (cpu_dbgreg_in),
    .rx_rd          (rx_rd),
    .tx_data        (tx_data),
    .tx_wr          (tx_wr),
    .active         (active),
    .cpu_r_nw       (cpu_r_nw),
    .cpu_a          (cpu_a),
    .cpu_dout       (cpu_dout),
    .cpu_dbgreg_sel (cpu_dbgreg_sel),
    .cpu_dbgreg_out (cpu_dbgreg_out),
    .cpu_dbgreg_wr  (cpu_dbgreg_wr)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #20 clk = ~clk;  // 40 ns period
  end

  ////////////////////////////////////////
  // FIFO, memory and register models
  ////////////////////////////////////////

  assign cpu_din       = mem[cpu_a];             // Combinational bus read
  assign cpu_dbgreg_in = regs[cpu_dbgreg_sel];

  always @(posedge clk)
  begin
    if (!cpu_r_nw)
      mem[cpu_a] <= cpu_dout;
    if (cpu_dbgreg_wr)
      regs[cpu_dbgreg_sel] <= cpu_dbgreg_out;
    if (rx_rd)
      void'(rx_q.pop_front());  // Head consumed at this edge
    if (tx_wr)
      tx_q.push_back(tx_data);
  end

  // Inputs change on the falling edge only
  always @(negedge clk)
  begin
    rx_empty <= (rx_q.size() == 0);
    rx_data  <= (rx_q.size() == 0) ? 8'h00 : rx_q[0];  // Show-ahead head
    case (full_mode)
      1: tx_full <= (($random(seed) & 3) == 0);
      2:
      begin
        if (full_left == 0)
        begin
          tx_full   <= ~tx_full;
          full_left = 1 + ($unsigned($random(seed)) % 16);
        end
        else
          full_left = full_left - 1;
      end
      default: tx_full <= 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    if (expected !== actual)
    begin
      $display("Mismatch %s: expected 0x%0h actual 0x%0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic start_test();
    test_err0 = errors;
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == test_err0)
      $display("test %s ok", name);
    else
    begin
      failed_tests++;
      $display("test %s failed with %0d errors", name, errors - test_err0);
    end
  endtask

  // Queue the packet behind the FIFO head, drop old replies
  task automatic send_pkt();
    @(posedge clk);
    tx_q.delete();
    foreach (pkt[k])
      rx_q.push_back(pkt[k]);
    pkt.delete();
  endtask

  task automatic push_header(input byte_t op, input addr_t a, input int n);
    pkt.push_back(op);
    pkt.push_back(a[7:0]);
    pkt.push_back(a[15:8]);
    pkt.push_back(n[7:0]);
    pkt.push_back(n[15:8]);
  endtask

  task automatic wait_rx_drain();
    int cyc;
    cyc = 0;
    while (rx_q.size() != 0 && cyc < 20000)
    begin
      @(negedge clk);
      cyc++;
    end
    if (rx_q.size() != 0)
    begin
      $display("Error: timeout waiting for receive FIFO to drain");
      errors++;
    end
    @(negedge clk);  // State settles after last pop
  endtask

  task automatic wait_replies(input int n, input int limit);
    int cyc;
    cyc = 0;
    while (tx_q.size() < n && cyc < limit)
    begin
      @(negedge clk);
      cyc++;
    end
    if (tx_q.size() < n)
    begin
      $display("Error: timeout waiting for reply, got %0d of %0d bytes", tx_q.size(), n);
      errors++;
    end
    repeat (4) @(negedge clk);  // Room for a stray extra byte
  endtask

  // Send pkt, expect one reply byte
  task automatic expect_single(input string name, input byte_t expected);
    send_pkt();
    wait_rx_drain();
    wait_replies(1, 200);
    compare_value({name, " count"}, 1, tx_q.size());
    if (tx_q.size() > 0)
      compare_value(name, expected, tx_q[0]);
  endtask

  task automatic echo_run(input int n);
    byte_t data [$];
    byte_t b;
    int    i;
    pkt.push_back(OP_ECHO);
    pkt.push_back(n[7:0]);
    pkt.push_back(n[15:8]);
    for (i = 0; i < n; i++)
    begin
      b = byte_t'($random(seed));
      data.push_back(b);
      pkt.push_back(b);
    end
    send_pkt();
    wait_rx_drain();
    wait_replies(n, 2000);
    compare_value("echo count", n, tx_q.size());
    for (i = 0; i < n && i < tx_q.size(); i++)
      compare_value("echo data", data[i], tx_q[i]);
  endtask

  task automatic mem_write(input addr_t a, input int n);
    addr_t ad;
    byte_t b;
    int    i;
    push_header(OP_CPU_MEM_WR, a, n);
    for (i = 0; i < n; i++)
    begin
      b  = byte_t'($random(seed));
      ad = a + addr_t'(i);  // Wraps at top of map
      exp_mem[ad] = b;
      pkt.push_back(b);
    end
    send_pkt();
    wait_rx_drain();
    for (i = 0; i < n; i++)
    begin
      ad = a + addr_t'(i);
      compare_value("mem write", exp_mem[ad], mem[ad]);
    end
  endtask

  task automatic mem_read(input string name, input addr_t a, input int n, input int limit);
    int i;
    push_header(OP_CPU_MEM_RD, a, n);
    send_pkt();
    wait_rx_drain();
    wait_replies(n, limit);
    compare_value({name, " count"}, n, tx_q.size());
    for (i = 0; i < n && i < tx_q.size(); i++)
      compare_value(name, exp_mem[a + addr_t'(i)], tx_q[i]);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic break_test();
    start_test();
    compare_value("active after reset", 0, active);
    pkt.push_back(OP_QUERY_DBG_BRK);
    expect_single("break query running", 8'h00);
    pkt.push_back(OP_DBG_BRK);
    send_pkt();
    wait_rx_drain();
    compare_value("break by command", 1, active);
    pkt.push_back(OP_QUERY_DBG_BRK);
    expect_single("break query held", 8'h01);
    pkt.push_back(OP_DBG_RUN);
    send_pkt();
    wait_rx_drain();
    compare_value("run clears active", 0, active);
    brk = 1'b1;  // One-cycle pin pulse
    @(negedge clk);
    brk = 1'b0;
    @(negedge clk);
    compare_value("break by pin", 1, active);
    finish_test("break");
  endtask

  task automatic echo_test();
    start_test();
    echo_run(rand_below(21));
    echo_run(0);
    pkt.push_back(OP_QUERY_DBG_BRK);
    expect_single("query after empty echo", 8'h01);
    finish_test("echo");
  endtask

  task automatic mem_test();
    addr_t a;
    int    n;
    start_test();
    a = addr_t'($random(seed));
    n = 1 + rand_below(32);
    full_mode = 1;
    mem_write(a, n);
    mem_read("mem read", a, n, 2000);
    mem_read("mem read empty", a, 0, 10);
    full_mode = 0;
    finish_test("cpu_mem");
  endtask

  task automatic reg_test();
    reg_sel_t sel;
    byte_t    d;
    int       k;
    start_test();
    for (k = 0; k < 4; k++)
    begin
      sel = reg_sel_t'($random(seed));
      d   = byte_t'($random(seed));
      exp_regs[sel] = d;
      pkt.push_back(OP_CPU_REG_WR);
      pkt.push_back({4'h0, sel});
      pkt.push_back(d);
      send_pkt();
      wait_rx_drain();
      compare_value("reg write", exp_regs[sel], regs[sel]);
      sel = reg_sel_t'($random(seed));  // Read back any register
      pkt.push_back(OP_CPU_REG_RD);
      pkt.push_back({4'h0, sel});
      expect_single("reg read", exp_regs[sel]);
    end
    finish_test("cpu_reg");
  endtask

  task automatic err_test();
    start_test();
    pkt.push_back(OP_QUERY_ERR_CODE);
    expect_single("err code clean", 8'h00);
    pkt.push_back(8'h09 + byte_t'(rand_below(247)));  // Any unused opcode
    send_pkt();
    wait_rx_drain();
    pkt.push_back(OP_QUERY_ERR_CODE);
    expect_single("err code set", 8'h02);
    pkt.push_back(OP_QUERY_ERR_CODE);
    expect_single("err code sticky", 8'h02);
    compare_value("break after unknown op", 1, active);
    finish_test("errors");
  endtask

  task automatic backpressure_test();
    addr_t a;
    int    n;
    start_test();
    a = addr_t'($random(seed));
    n = 200 + rand_below(100);
    mem_write(a, n);
    full_mode = 2;  // Long full stretches during the read
    mem_read("long read", a, n, 20000);
    full_mode = 0;
    finish_test("backpressure");
  endtask

  initial
  begin
    int i;
    seed         = 57;
    rst          = 1'b1;
    brk          = 1'b0;
    rx_data      = 8'h00;
    rx_empty     = 1'b1;
    tx_full      = 1'b0;
    full_mode    = 0;
    full_left    = 0;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    failed_tests = 0;
    test_err0    = 0;
    for (i = 0; i < 65536; i++)
    begin
      mem[i]     = i[7:0] ^ (i[15:8] * 8'd3) ^ 8'ha5;  // Every address bit counts
      exp_mem[i] = mem[i];
    end
    for (i = 0; i < 16; i++)
    begin
      regs[i]     = byte_t'(i * 37 + 11);
      exp_regs[i] = regs[i];
    end

    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    break_test();
    echo_test();
    mem_test();
    reg_test();
    err_test();
    backpressure_test();

    errors = errors + dbg_top_i.dbg_properties_i.fail_count;  // Protocol rule failures
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire
